//--- aluStage.sv
`include "cpu_consts.svh"

module aluStage (
    input  logic               clk,
    input  logic               arstN,
    input  cpuPkg::busSrcT     busSrc,
    input  logic [`DATA_W-1:0] regData,
    input  logic [`DATA_W-1:0] cSignExtended,
    input  logic               yIn,
    input  logic               zIn,
    input  cpuPkg::aluOpT      aluOp,
    output logic [`DATA_W-1:0] zOut
);
    logic [`DATA_W-1:0] bus;
    logic [`DATA_W-1:0] yReg;
    logic [`DATA_W-1:0] aluResult;

    always_comb begin
        case (busSrc)
            cpuPkg::srcReg: bus = regData;
            cpuPkg::srcC:   bus = cSignExtended;
            cpuPkg::srcZ:   bus = zOut;
            default:        bus = regData;
        endcase
    end

    // Y holds the first operand, the bus carries the second
    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: aluResult = yReg + bus;
            cpuPkg::aluSub: aluResult = yReg - bus;  // wraps modulo 2^32
            cpuPkg::aluAnd: aluResult = yReg & bus;
            default:        aluResult = yReg | bus;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            yReg <= '0;
            zOut <= '0;
        end else begin
            if (yIn) begin
                yReg <= bus;
            end
            if (zIn) begin
                zOut <= aluResult;
            end
        end
    end

endmodule

//--- controlUnit.sv
`include "cpu_consts.svh"

module controlUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  qNotEmpty,
    input  cpuPkg::instrU         qWord,
    output logic                  qPop,
    output cpuPkg::instrU         irOut,
    output logic                  gra,
    output logic                  grb,
    output logic                  grc,
    output logic                  rIn,
    output logic                  rOut,
    output logic                  baOut,
    output cpuPkg::busSrcT        busSrc,
    output logic                  yIn,
    output logic                  zIn,
    output cpuPkg::aluOpT         aluOp,
    output logic                  wbValid,
    output logic [`REG_SEL_W-1:0] wbAddr
);
    logic [1:0] phase;
    logic       inT0;
    logic       inT1;
    logic       inT2;
    logic       inT3;
    logic       immForm;
    logic       validOp;

    assign inT0 = (phase == 2'd0);
    assign inT1 = (phase == 2'd1);
    assign inT2 = (phase == 2'd2);
    assign inT3 = (phase == 2'd3);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= 2'd0;
            irOut <= '0;
        end else begin
            if (qPop) begin
                irOut <= qWord;
            end
            if (!inT0 || qNotEmpty) begin
                phase <= phase + 2'd1;  // T3 rolls back to T0
            end
        end
    end

    always_comb begin
        aluOp   = cpuPkg::aluAdd;
        immForm = 1'b0;
        validOp = 1'b1;
        case (irOut.regForm.op)
            cpuPkg::opAdd:  aluOp = cpuPkg::aluAdd;
            cpuPkg::opSub:  aluOp = cpuPkg::aluSub;
            cpuPkg::opAnd:  aluOp = cpuPkg::aluAnd;
            cpuPkg::opOr:   aluOp = cpuPkg::aluOr;
            cpuPkg::opAddi: immForm = 1'b1;
            cpuPkg::opAndi: begin
                aluOp   = cpuPkg::aluAnd;
                immForm = 1'b1;
            end
            cpuPkg::opOri: begin
                aluOp   = cpuPkg::aluOr;
                immForm = 1'b1;
            end
            default: validOp = 1'b0;  // no-op, still walks all four phases
        endcase
    end

    assign qPop  = inT0 & qNotEmpty;
    assign grb   = inT1;  // rb onto the bus, R0 reads zero
    assign baOut = inT1;
    assign yIn   = inT1;
    assign grc   = inT2 & ~immForm;
    assign rOut  = inT1 | (inT2 & ~immForm);
    assign zIn   = inT2;
    assign gra   = inT3;
    assign rIn   = inT3 & validOp;

    assign busSrc = (inT2 & immForm) ? cpuPkg::srcC :
                    inT3             ? cpuPkg::srcZ : cpuPkg::srcReg;

    assign wbValid = inT3 & validOp;
    assign wbAddr  = irOut.regForm.ra;

endmodule

//--- cpuPkg.sv
`include "cpu_consts.svh"

package cpuPkg;

    // codes outside this list are treated as no-ops
    typedef enum logic [`OP_W-1:0] {
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14
    } opcodeT;

    // one instruction word, seen either as register or immediate form
    typedef union packed {
        struct packed {
            opcodeT                op;
            logic [`REG_SEL_W-1:0] ra;
            logic [`REG_SEL_W-1:0] rb;
            logic [`REG_SEL_W-1:0] rc;
            logic [`RC_PAD_W-1:0]  pad;
        } regForm;
        struct packed {
            opcodeT                op;
            logic [`REG_SEL_W-1:0] ra;
            logic [`REG_SEL_W-1:0] rb;
            logic [`IMM_PAD_W-1:0] pad;
            logic [`C_W-1:0]       c;
        } immForm;
    } instrU;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOpT;

    typedef enum logic [1:0] {srcReg, srcC, srcZ} busSrcT;

endpackage

//--- cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// word and register file sizes
`define DATA_W      32
`define REG_COUNT   16
`define REG_SEL_W   4

// instruction queue, depth is also the sender's credit count after reset
`define QUEUE_DEPTH 4
`define QPTR_W      2

// instruction word fields, op [31:27], ra [26:23], rb [22:19]
`define OP_W        5
`define C_W         18
`define C_SIGN_BIT  17
`define RC_PAD_W    15  // unused low bits below rc [18:15] in register form
`define IMM_PAD_W   1   // bit 18 sits between rb and the C field

`endif

//--- instrQueue.sv
`include "cpu_consts.svh"

module instrQueue (
    input  logic          clk,
    input  logic          arstN,
    input  logic          instrValid,
    input  cpuPkg::instrU instrWord,
    input  logic          qPop,
    output logic          qNotEmpty,
    output cpuPkg::instrU qWord,
    output logic          instrCredit
);
    cpuPkg::instrU      slots [`QUEUE_DEPTH];
    logic [`QPTR_W-1:0] wrPtr;
    logic [`QPTR_W-1:0] rdPtr;
    logic [`QPTR_W:0]   count;

    // sender holds a credit for every push, so no full check is needed
    always_ff @(posedge clk) begin
        if (instrValid) begin
            slots[wrPtr] <= instrWord;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            instrCredit <= 1'b0;
        end else begin
            if (instrValid) begin
                wrPtr <= wrPtr + 1'b1;  // wraps at depth 4
            end
            if (qPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({instrValid, qPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            instrCredit <= qPop;  // one credit back per freed slot
        end
    end

    assign qNotEmpty = (count != '0);
    assign qWord     = slots[rdPtr];

endmodule

//--- miniCpu.sv
`include "cpu_consts.svh"

module miniCpu (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  cpuPkg::instrU         instrWord,
    output logic                  instrCredit,
    output logic                  wbValid,
    output logic [`REG_SEL_W-1:0] wbAddr,
    output logic [`DATA_W-1:0]    wbData
);
    logic                  qNotEmpty;
    logic                  qPop;
    cpuPkg::instrU         qWord;
    cpuPkg::instrU         irOut;
    logic                  gra;
    logic                  grb;
    logic                  grc;
    logic                  rIn;
    logic                  rOut;
    logic                  baOut;
    logic                  yIn;
    logic                  zIn;
    cpuPkg::busSrcT        busSrc;
    cpuPkg::aluOpT         aluOp;
    logic [`REG_COUNT-1:0] regInSel;
    logic [`REG_COUNT-1:0] regOutSel;
    logic [`DATA_W-1:0]    cSignExtended;
    logic [`DATA_W-1:0]    regData;
    logic [`DATA_W-1:0]    zOut;

    instrQueue uQueue (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instrWord(instrWord),
        .qPop(qPop), .qNotEmpty(qNotEmpty), .qWord(qWord), .instrCredit(instrCredit)
    );

    controlUnit uControl (
        .clk(clk), .arstN(arstN), .qNotEmpty(qNotEmpty), .qWord(qWord), .qPop(qPop),
        .irOut(irOut), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
        .baOut(baOut), .busSrc(busSrc), .yIn(yIn), .zIn(zIn), .aluOp(aluOp),
        .wbValid(wbValid), .wbAddr(wbAddr)
    );

    selectAndEncode uSelect (
        .irOut(irOut), .gra(gra), .grb(grb), .grc(grc), .rIn(rIn), .rOut(rOut),
        .baOut(baOut), .regInSel(regInSel), .regOutSel(regOutSel),
        .cSignExtended(cSignExtended)
    );

    registerFile uRegs (
        .clk(clk), .arstN(arstN), .regInSel(regInSel), .regOutSel(regOutSel),
        .baOut(baOut), .wrData(zOut), .regData(regData)
    );

    aluStage uAlu (
        .clk(clk), .arstN(arstN), .busSrc(busSrc), .regData(regData),
        .cSignExtended(cSignExtended), .yIn(yIn), .zIn(zIn), .aluOp(aluOp), .zOut(zOut)
    );

    assign wbData = zOut;  // Z still holds the result during T3

endmodule

//--- registerFile.sv
`include "cpu_consts.svh"

module registerFile (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [`REG_COUNT-1:0] regInSel,
    input  logic [`REG_COUNT-1:0] regOutSel,
    input  logic                  baOut,
    input  logic [`DATA_W-1:0]    wrData,
    output logic [`DATA_W-1:0]    regData
);
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regInSel[i]) begin
                    regs[i] <= wrData;
                end
            end
        end
    end

    // and-or read over the one-hot select
    always_comb begin
        regData = regs[0] & {`DATA_W{regOutSel[0] & ~baOut}};  // R0 is zero as a base
        for (int i = 1; i < `REG_COUNT; i++) begin
            regData = regData | (regs[i] & {`DATA_W{regOutSel[i]}});
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the miniCpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tbMiniCpu -o simMiniCpu
./obj_dir/simMiniCpu

//--- selectAndEncode.sv
`include "cpu_consts.svh"

module selectAndEncode (
    input  cpuPkg::instrU        irOut,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    output logic [`REG_COUNT-1:0] regInSel,
    output logic [`REG_COUNT-1:0] regOutSel,
    output logic [`DATA_W-1:0]    cSignExtended
);
    logic [`REG_SEL_W-1:0] regSel;
    logic [`REG_COUNT-1:0] oneHot;
    logic                  outEn;

    // only one of the gr strobes is high in any phase
    assign regSel = ({`REG_SEL_W{gra}} & irOut.regForm.ra)
                  | ({`REG_SEL_W{grb}} & irOut.regForm.rb)
                  | ({`REG_SEL_W{grc}} & irOut.regForm.rc);

    // 4-to-16 decode
    always_comb begin
        oneHot = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            if (regSel == i[`REG_SEL_W-1:0]) begin
                oneHot[i] = 1'b1;
            end
        end
    end

    assign outEn     = rOut | baOut;
    assign regInSel  = oneHot & {`REG_COUNT{rIn}};
    assign regOutSel = oneHot & {`REG_COUNT{outEn}};

    assign cSignExtended = {{(`DATA_W - `C_W){irOut.immForm.c[`C_SIGN_BIT]}},
                            irOut.immForm.c};

endmodule

//--- tbMiniCpu.sv
`include "cpu_consts.svh"

module tbMiniCpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS        = 20;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 40;  // reset, idle check and drain

    logic                  clk;
    logic                  arstN;
    logic                  instrValid;
    cpuPkg::instrU         instrWord;
    logic                  instrCredit;
    logic                  wbValid;
    logic [`REG_SEL_W-1:0] wbAddr;
    logic [`DATA_W-1:0]    wbData;

    // one row per instruction, expected write-back beside it
    logic [`DATA_W-1:0]    rowWord [NUM_ROWS];
    logic                  rowWb   [NUM_ROWS];
    logic [`REG_SEL_W-1:0] rowAddr [NUM_ROWS];
    logic [`DATA_W-1:0]    rowData [NUM_ROWS];
    int                    numRows;
    int                    numWb;

    integer seed;
    int     credits;      // credits held by the sender
    int     sent;
    int     rowIdx;       // next row the monitor expects
    int     wbSeen;
    int     cycle;
    int     lastWbCycle;

    miniCpu dut_i (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instrWord(instrWord),
        .instrCredit(instrCredit), .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // op [31:27], ra [26:23], rb [22:19], rc [18:15]
    function automatic logic [31:0] encReg(input logic [4:0] op, input logic [3:0] ra,
                                           input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    // C field in [17:0]
    function automatic logic [31:0] encImm(input logic [4:0] op, input logic [3:0] ra,
                                           input logic [3:0] rb, input logic [17:0] c);
        return {op, ra, rb, 1'b0, c};
    endfunction

    task automatic addRow(input logic [31:0] word, input logic wb,
                          input logic [3:0] addr, input logic [31:0] data);
        rowWord[numRows] = word;
        rowWb[numRows]   = wb;
        rowAddr[numRows] = addr;
        rowData[numRows] = data;
        numRows++;
        if (wb) begin
            numWb++;
        end
    endtask

    task automatic loadTable();
        // loads from R0, bit 17 of C sets the upper bits
        addRow(encImm(cpuPkg::opAddi, 4'd1, 4'd0, 18'h00005), 1'b1, 4'd1, 32'h0000_0005);
        addRow(encImm(cpuPkg::opAddi, 4'd2, 4'd0, 18'h3fffd), 1'b1, 4'd2, 32'hffff_fffd);
        addRow(encImm(cpuPkg::opAddi, 4'd3, 4'd0, 18'h1ffff), 1'b1, 4'd3, 32'h0001_ffff);
        addRow(encImm(cpuPkg::opAddi, 4'd4, 4'd0, 18'h20000), 1'b1, 4'd4, 32'hfffe_0000);
        // register form, rb op rc
        addRow(encReg(cpuPkg::opAdd, 4'd5, 4'd1, 4'd3), 1'b1, 4'd5, 32'h0002_0004);
        addRow(encReg(cpuPkg::opSub, 4'd6, 4'd1, 4'd3), 1'b1, 4'd6, 32'hfffe_0006);
        addRow(encReg(cpuPkg::opAnd, 4'd7, 4'd5, 4'd3), 1'b1, 4'd7, 32'h0000_0004);
        addRow(encReg(cpuPkg::opOr, 4'd8, 4'd4, 4'd1), 1'b1, 4'd8, 32'hfffe_0005);
        // R0 gets 0x123, reads zero as base but 0x123 as rc
        addRow(encImm(cpuPkg::opAddi, 4'd0, 4'd0, 18'h00123), 1'b1, 4'd0, 32'h0000_0123);
        addRow(encImm(cpuPkg::opAddi, 4'd9, 4'd0, 18'h00007), 1'b1, 4'd9, 32'h0000_0007);
        addRow(encReg(cpuPkg::opAdd, 4'd10, 4'd1, 4'd0), 1'b1, 4'd10, 32'h0000_0128);
        addRow(encReg(5'd9, 4'd12, 4'd1, 4'd2), 1'b0, 4'd0, 32'h0);  // no-op
        addRow(encReg(cpuPkg::opSub, 4'd11, 4'd0, 4'd1), 1'b1, 4'd11, 32'hffff_fffb);
        addRow(encImm(cpuPkg::opAndi, 4'd12, 4'd2, 18'h0ff0f), 1'b1, 4'd12, 32'h0000_ff0d);
        addRow(encImm(cpuPkg::opOri, 4'd13, 4'd1, 18'h3fff0), 1'b1, 4'd13, 32'hffff_fff5);
        addRow(encReg(5'd0, 4'd13, 4'd5, 4'd6), 1'b0, 4'd0, 32'h0);  // no-op, ra would clobber r13
        addRow(encReg(cpuPkg::opAdd, 4'd14, 4'd13, 4'd12), 1'b1, 4'd14, 32'h0000_ff02);
        addRow(encReg(cpuPkg::opSub, 4'd15, 4'd6, 4'd14), 1'b1, 4'd15, 32'hfffd_0104);
        addRow(encReg(cpuPkg::opOr, 4'd3, 4'd9, 4'd10), 1'b1, 4'd3, 32'h0000_012f);
        addRow(encReg(cpuPkg::opAnd, 4'd1, 4'd3, 4'd8), 1'b1, 4'd1, 32'h0000_0005);
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH %s: got %h, expected %h", name, got, expected));
        end
    endtask

    task automatic watchWriteBack();
        cycle++;
        if (wbValid) begin
            if (cycle - lastWbCycle < 4) begin
                failRun($sformatf("write-backs only %0d cycles apart", cycle - lastWbCycle));
            end
            lastWbCycle = cycle;
            while (rowIdx < numRows && !rowWb[rowIdx]) begin
                rowIdx++;  // no-op rows expect nothing
            end
            if (rowIdx >= numRows) begin
                failRun("write-back seen after the last table entry");
            end else begin
                checkValue("wbAddr", 32'(wbAddr), 32'(rowAddr[rowIdx]));
                checkValue("wbData", wbData, rowData[rowIdx]);
                rowIdx++;
                wbSeen++;
            end
        end
    endtask

    // one cycle of the sender, outputs sampled and inputs driven on the falling edge
    task automatic stepSender();
        logic [31:0] r;
        @(negedge clk);
        watchWriteBack();
        if (instrCredit) begin
            credits++;
        end
        r = $random(seed);
        instrValid = 1'b0;
        if (sent < numRows && credits > 0 && r[2:0] < 3'd3) begin
            instrWord  = rowWord[sent];
            instrValid = 1'b1;
            credits--;
            sent++;
        end
        if (credits < 0 || credits > `QUEUE_DEPTH) begin
            failRun($sformatf("sender credit count left its range, now %0d", credits));
        end
    endtask

    initial begin
        seed        = 32'h2687;
        arstN       = 1'b0;
        instrValid  = 1'b0;
        instrWord   = '0;
        credits     = `QUEUE_DEPTH;
        sent        = 0;
        rowIdx      = 0;
        wbSeen      = 0;
        cycle       = 0;
        lastWbCycle = -100;
        numRows     = 0;
        numWb       = 0;
        loadTable();
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        repeat (6) begin
            @(negedge clk);
            checkValue("wbValid", 32'(wbValid), 32'd0);  // nothing sent yet
            checkValue("instrCredit", 32'(instrCredit), 32'd0);
        end
        while (wbSeen < numWb) begin
            stepSender();
        end
        repeat (8) begin
            stepSender();  // drain, a stray write-back fails here
        end
        if (credits == `QUEUE_DEPTH) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            failRun($sformatf("sender holds %0d credits at the end instead of %0d",
                              credits, `QUEUE_DEPTH));
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        failRun($sformatf("timeout, write-backs missing, %0d of %0d arrived", wbSeen, numWb));
    end

endmodule

//--- vlog.f
+incdir+.
cpuPkg.sv
instrQueue.sv
selectAndEncode.sv
registerFile.sv
aluStage.sv
controlUnit.sv
miniCpu.sv
tbMiniCpu.sv
